//--- source/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

    // bit period is divisor + 1 clocks
    localparam int DIV_W = 10;

    // fixed 8N1 frame, no parity
    localparam int DATA_BITS = 8;

    // idle and stop level
    localparam logic LINE_IDLE = 1'b1;
    // start bit level
    localparam logic LINE_START = ~LINE_IDLE;

endpackage

`default_nettype wire

//--- source/uart_host_pkg.sv
`default_nettype none

package uart_host_pkg;

    import uart_line_pkg::*;

    // entries per fifo, same for both directions
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // receive credits; must be able to hold FIFO_DEPTH
    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

    // captured byte plus the stop bit check result
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 frame_err; // stop bit sampled low
    } rx_msg_t;

endpackage

`default_nettype wire

//--- source/byte_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module byte_fifo
    import uart_host_pkg::*;
#(
    parameter int WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] head_o,
    output logic             empty_o,
    output logic             full_o
);

    logic [WIDTH-1:0]   mem_q [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_AW:0]   count_q;
    logic               do_push;
    logic               do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (FIFO_AW + 1)'(FIFO_DEPTH));

    assign do_push = push_i && !full_o;  // push on full is dropped
    assign do_pop  = pop_i && !empty_o;

    assign head_o = mem_q[rd_ptr_q]; // fall-through head

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

//--- source/uart_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module uart_receiver
    import uart_line_pkg::*;
    import uart_host_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             rx_i,
    input  logic             rx_en_i,
    input  logic [DIV_W-1:0] divisor_i,
    output logic             byte_valid_o,
    output rx_msg_t          byte_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_e;

    rx_state_e                    state_q;
    logic [DIV_W-1:0]             cnt_q;
    logic [$clog2(DATA_BITS)-1:0] bit_q;
    logic [DATA_BITS-1:0]         shift_q;
    logic                         rx_q;
    logic                         half_hit;
    logic                         full_hit;
    logic                         start_edge;

    assign half_hit = (cnt_q == (divisor_i >> 1)); // middle of start bit
    assign full_hit = (cnt_q == divisor_i);        // one bit period after last sample

    // falling edge only, so a line held low after a bad stop bit does not restart
    assign start_edge = rx_en_i && (rx_q == LINE_IDLE) && (rx_i == LINE_START);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= st_idle;
            cnt_q        <= '0;
            bit_q        <= '0;
            rx_q         <= LINE_IDLE;
            byte_valid_o <= 1'b0;
        end else begin
            rx_q         <= rx_i;
            byte_valid_o <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start_edge) begin
                        state_q <= st_start;
                        cnt_q   <= '0;
                    end
                end
                st_start: begin
                    if (half_hit) begin
                        cnt_q <= '0;
                        bit_q <= '0;
                        // glitch shorter than half a bit goes back to idle
                        state_q <= (rx_i == LINE_START) ? st_data : st_idle;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                st_data: begin
                    if (full_hit) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == DATA_BITS - 1) begin
                            state_q <= st_stop;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                st_stop: begin
                    if (full_hit) begin
                        cnt_q        <= '0;
                        state_q      <= st_idle;
                        byte_valid_o <= 1'b1; // message lands next cycle
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // data path, one sample per bit centre
    always_ff @(posedge clk_i) begin
        if (state_q == st_data && full_hit) begin
            shift_q <= {rx_i, shift_q[DATA_BITS-1:1]}; // lsb first
        end
        if (state_q == st_stop && full_hit) begin
            byte_o.data      <= shift_q;
            byte_o.frame_err <= (rx_i != LINE_IDLE);
        end
    end

endmodule

`default_nettype wire

//--- source/uart_transmitter.sv
`timescale 1ns/10ps
`default_nettype none

module uart_transmitter
    import uart_line_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [DIV_W-1:0]     divisor_i,
    input  logic [DATA_BITS-1:0] data_i,
    input  logic                 ready_i,
    output logic                 fetch_o,
    output logic                 tx_o
);

    logic                           busy_q;
    logic [DIV_W-1:0]               cnt_q;
    logic [$clog2(DATA_BITS+2)-1:0] bit_q;   // 0 is start, DATA_BITS+1 is stop
    logic [DATA_BITS:0]             shift_q; // data with stop level on top
    logic                           bit_end;

    // take the fifo head as soon as the line is free
    assign fetch_o = !busy_q && ready_i;

    assign bit_end = (cnt_q == divisor_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            bit_q  <= '0;
            tx_o   <= LINE_IDLE;
        end else if (fetch_o) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
            bit_q  <= '0;
            tx_o   <= LINE_START;
        end else if (busy_q) begin
            if (bit_end) begin
                cnt_q <= '0;
                if (bit_q == DATA_BITS + 1) begin
                    busy_q <= 1'b0; // end of stop bit, line already high
                end else begin
                    tx_o  <= shift_q[0];
                    bit_q <= bit_q + 1'b1;
                end
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // shift register for the data and stop bits
    always_ff @(posedge clk_i) begin
        if (fetch_o) begin
            shift_q <= {LINE_IDLE, data_i};
        end else if (busy_q && bit_end) begin
            shift_q <= {LINE_IDLE, shift_q[DATA_BITS:1]};
        end
    end

endmodule

`default_nettype wire

//--- source/uart_core.sv
`timescale 1ns/10ps
`default_nettype none

module uart_core
    import uart_line_pkg::*;
    import uart_host_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 rx_i,
    input  logic                 rx_en_i,
    input  logic [DIV_W-1:0]     divisor_i,
    input  logic                 tx_valid_i,
    input  logic [DATA_BITS-1:0] tx_data_i,
    input  logic                 rx_credit_i,
    output logic                 tx_o,
    output logic                 tx_credit_o,
    output logic                 rx_valid_o,
    output rx_msg_t              rx_msg_o,
    output logic                 overrun_o
);

    logic                 fetch;
    logic [DATA_BITS-1:0] tx_head;
    logic                 tx_empty;

    logic                 rx_byte_valid;
    rx_msg_t              rx_byte;
    rx_msg_t              rx_head;
    logic                 rx_push;
    logic                 rx_empty;
    logic                 rx_full;

    logic [CREDIT_W-1:0]  credit_cnt;
    logic                 deliver;

    // transmit path
    byte_fifo #(
        .WIDTH (DATA_BITS)
    ) tx_fifo_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (tx_valid_i),
        .push_data_i (tx_data_i),
        .pop_i       (fetch),
        .head_o      (tx_head),
        .empty_o     (tx_empty),
        .full_o      ()          // host credits keep it from filling
    );

    uart_transmitter tx_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .divisor_i (divisor_i),
        .data_i    (tx_head),
        .ready_i   (!tx_empty),
        .fetch_o   (fetch),
        .tx_o      (tx_o)
    );

    assign tx_credit_o = fetch; // one credit back per byte sent to the line

    // receive path
    uart_receiver rx_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rx_i         (rx_i),
        .rx_en_i      (rx_en_i),
        .divisor_i    (divisor_i),
        .byte_valid_o (rx_byte_valid),
        .byte_o       (rx_byte)
    );

    assign rx_push = rx_byte_valid && !rx_full;

    byte_fifo #(
        .WIDTH ($bits(rx_msg_t))
    ) rx_fifo_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (rx_push),
        .push_data_i (rx_byte),
        .pop_i       (deliver),
        .head_o      (rx_head),
        .empty_o     (rx_empty),
        .full_o      (rx_full)
    );

    // hand out a byte only against a host grant
    assign deliver = (credit_cnt != '0) && !rx_empty;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_cnt <= '0;
            rx_valid_o <= 1'b0;
            overrun_o  <= 1'b0;
        end else begin
            case ({rx_credit_i, deliver})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            rx_valid_o <= deliver;
            if (rx_byte_valid && rx_full) begin
                overrun_o <= 1'b1; // sticky, byte is lost
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (deliver) begin
            rx_msg_o <= rx_head;
        end
    end

endmodule

`default_nettype wire

//--- bench/uart_core_chk.sv
`timescale 1ns/10ps
`default_nettype none

module uart_core_chk
    import uart_line_pkg::*;
    import uart_host_pkg::*;
(
    input logic                clk_i,
    input logic                rst_i,
    input logic                tx_i,
    input logic                tx_credit_i,
    input logic                rx_valid_i,
    input logic [CREDIT_W-1:0] credit_cnt_i
);

    int fail_count = 0;

    // rx_valid_o is registered, so the credit was held one cycle earlier
    assert property (@(posedge clk_i) disable iff (rst_i)
        rx_valid_i |-> ($past(credit_cnt_i) != '0))
        else begin
            $error("rx_valid_o asserted with no receive credit held");
            fail_count++;
        end

    assert property (@(posedge clk_i) rst_i |=> (tx_i == LINE_IDLE))
        else begin
            $error("tx_o not idle in the cycle after reset");
            fail_count++;
        end

    // a frame lasts far longer than one cycle
    assert property (@(posedge clk_i) disable iff (rst_i)
        tx_credit_i |=> !tx_credit_i)
        else begin
            $error("tx_credit_o high on two consecutive cycles");
            fail_count++;
        end

endmodule

bind uart_core uart_core_chk chk_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .tx_i         (tx_o),
    .tx_credit_i  (tx_credit_o),
    .rx_valid_i   (rx_valid_o),
    .credit_cnt_i (credit_cnt)
);

`default_nettype wire

//--- bench/uart_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module uart_core_tb
    import uart_line_pkg::*;
    import uart_host_pkg::*;
();

    localparam int DIVISOR         = 7;
    localparam int BIT_CYCLES      = DIVISOR + 1;
    localparam int FRAME_CYCLES    = 10 * BIT_CYCLES; // start, 8 data, stop
    // loopback, back-pressure, framing, false start and overrun in turn
    localparam int TOTAL_FRAMES    = 4 + 3 + 1 + 2 + FIFO_DEPTH + 1;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_CYCLES + 500;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 rx_en;
    logic [DIV_W-1:0]     divisor;
    logic                 tx_valid;
    logic [DATA_BITS-1:0] tx_data;
    logic                 rx_credit;
    logic                 tx;
    logic                 tx_credit;
    logic                 rx_valid;
    rx_msg_t              rx_msg;
    logic                 overrun;
    logic                 loopback;
    logic                 rx_drv;
    logic                 rx_line;

    logic [31:0] lfsr_state = 32'h189f;
    rx_msg_t     got_q [$];
    int          tx_credits = FIFO_DEPTH; // host side transmit credits
    int          tx_pulses  = 0;
    int          tests      = 0;
    int          checks     = 0;
    int          errors     = 0;

    assign rx_line = loopback ? tx : rx_drv; // handmade frames when loopback is off

    uart_core uart_core_inst (
        .clk_i       (clk),
        .rst_i       (rst),
        .rx_i        (rx_line),
        .rx_en_i     (rx_en),
        .divisor_i   (divisor),
        .tx_valid_i  (tx_valid),
        .tx_data_i   (tx_data),
        .rx_credit_i (rx_credit),
        .tx_o        (tx),
        .tx_credit_o (tx_credit),
        .rx_valid_o  (rx_valid),
        .rx_msg_o    (rx_msg),
        .overrun_o   (overrun)
    );

    always #20 clk = ~clk;

    // outputs settle after the rising edge, so collect them on the falling one
    always @(negedge clk) begin
        if (!rst) begin
            if (rx_valid) begin
                got_q.push_back(rx_msg);
            end
            if (tx_credit) begin
                tx_pulses++;
                tx_credits++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // right shifting form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_next(input logic [7:0] exp_data, input logic exp_err);
        rx_msg_t msg;
        checks++;
        assert (got_q.size() != 0) else begin
            $display("ERROR at %0t: expected a received byte but none was delivered", $time);
            errors++;
        end
        if (got_q.size() != 0) begin
            msg = got_q.pop_front();
            check_value("rx_msg_o.data", 32'(msg.data), 32'(exp_data));
            check_value("rx_msg_o.frame_err", 32'(msg.frame_err), 32'(exp_err));
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int waited;
        waited = 0;
        while (tx_credits == 0 && waited < 2 * FRAME_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        checks++;
        assert (tx_credits > 0) else begin
            $display("ERROR at %0t: no transmit credit came back in time", $time);
            errors++;
        end
        @(posedge clk);
        tx_valid <= 1'b1;
        tx_data  <= b;
        tx_credits--;
        @(posedge clk);
        tx_valid <= 1'b0;
    endtask

    task automatic grant_credit();
        @(posedge clk);
        rx_credit <= 1'b1;
        @(posedge clk);
        rx_credit <= 1'b0;
    endtask

    task automatic wait_rx(input int n, input int max_cycles);
        int waited;
        waited = 0;
        while (got_q.size() < n && waited < max_cycles) begin
            @(posedge clk);
            waited++;
        end
        checks++;
        assert (got_q.size() >= n) else begin
            $display("ERROR at %0t: timed out waiting for %0d received bytes, have %0d",
                     $time, n, got_q.size());
            errors++;
        end
    endtask

    task automatic wait_tx_pulses(input int target, input int max_cycles);
        int waited;
        waited = 0;
        while (tx_pulses < target && waited < max_cycles) begin
            @(posedge clk);
            waited++;
        end
        checks++;
        assert (tx_pulses >= target) else begin
            $display("ERROR at %0t: timed out waiting for transmit credit returns", $time);
            errors++;
        end
    endtask

    // start bit, data lsb first, then the given stop level
    task automatic drive_frame(input logic [7:0] b, input logic stop);
        logic [9:0] bits;
        bits = {stop, b, LINE_START};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_drv <= bits[i];
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
        @(posedge clk);
        rx_drv <= LINE_IDLE;
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, errors - errs_at_start);
        end
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_value("tx_o", 32'(tx), 32'(LINE_IDLE));
        check_value("tx_credit_o", 32'(tx_credit), 32'h0);
        check_value("rx_valid_o", 32'(rx_valid), 32'h0);
        check_value("overrun_o", 32'(overrun), 32'h0);
        finish_test("reset state", e0);
    endtask

    task automatic test_loopback();
        logic [7:0] sent [$];
        logic [7:0] b;
        int         e0;
        int         p0;
        e0 = errors;
        p0 = tx_pulses;
        @(posedge clk);
        loopback <= 1'b1;
        repeat (4) grant_credit(); // receive slots handed out ahead
        for (int i = 0; i < 4; i++) begin
            random_byte(b);
            sent.push_back(b);
            send_byte(b);
        end
        wait_rx(4, 6 * FRAME_CYCLES);
        check_value("tx_credit_o pulses", 32'(tx_pulses - p0), 32'd4);
        foreach (sent[i]) begin
            check_next(sent[i], 1'b0);
        end
        finish_test("loopback", e0);
    endtask

    task automatic test_back_pressure();
        logic [7:0] sent [$];
        logic [7:0] b;
        int         e0;
        int         p0;
        e0 = errors;
        p0 = tx_pulses;
        for (int i = 0; i < 3; i++) begin
            random_byte(b);
            sent.push_back(b);
            send_byte(b);
        end
        wait_tx_pulses(p0 + 3, 4 * FRAME_CYCLES);
        repeat (FRAME_CYCLES + BIT_CYCLES) @(posedge clk); // last frame fully received
        check_value("received byte count", got_q.size(), 32'd0);
        foreach (sent[i]) begin
            grant_credit();
            wait_rx(1, BIT_CYCLES);
            repeat (4) @(posedge clk);
            check_value("received byte count", got_q.size(), 32'd1);
            check_next(sent[i], 1'b0);
        end
        finish_test("credit back-pressure", e0);
    endtask

    task automatic test_framing_error();
        logic [7:0] b;
        int         e0;
        e0 = errors;
        @(posedge clk);
        loopback <= 1'b0;
        grant_credit();
        random_byte(b);
        drive_frame(b, ~LINE_IDLE);
        wait_rx(1, FRAME_CYCLES);
        check_next(b, 1'b1);
        finish_test("framing error", e0);
    endtask

    task automatic test_false_start_overrun();
        logic [7:0] sent [$];
        logic [7:0] b;
        int         e0;
        int         p0;
        e0 = errors;
        grant_credit();
        @(posedge clk);
        rx_drv <= LINE_START;
        repeat (2) @(posedge clk); // well under half a bit
        rx_drv <= LINE_IDLE;
        repeat (FRAME_CYCLES) @(posedge clk);
        check_value("received byte count", got_q.size(), 32'd0);
        random_byte(b);
        drive_frame(b, LINE_IDLE); // receiver still usable after the glitch
        wait_rx(1, FRAME_CYCLES);
        check_next(b, 1'b0);

        @(posedge clk);
        loopback <= 1'b1;
        p0 = tx_pulses;
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            random_byte(b);
            sent.push_back(b);
            send_byte(b);
        end
        wait_tx_pulses(p0 + FIFO_DEPTH + 1, (FIFO_DEPTH + 2) * FRAME_CYCLES);
        repeat (FRAME_CYCLES + BIT_CYCLES) @(posedge clk);
        check_value("overrun_o", 32'(overrun), 32'h1);
        check_value("received byte count", got_q.size(), 32'd0);
        repeat (FIFO_DEPTH) grant_credit();
        wait_rx(FIFO_DEPTH, 2 * BIT_CYCLES);
        repeat (BIT_CYCLES) @(posedge clk);
        check_value("received byte count", got_q.size(), 32'(FIFO_DEPTH));
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            check_next(sent[i], 1'b0);
        end
        finish_test("false start and overrun", e0);
    endtask

    initial begin
        rst       <= 1'b1;
        rx_en     <= 1'b1;
        divisor   <= DIV_W'(DIVISOR);
        tx_valid  <= 1'b0;
        tx_data   <= '0;
        rx_credit <= 1'b0;
        rx_drv    <= LINE_IDLE;
        loopback  <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        test_reset_state();
        test_loopback();
        test_back_pressure();
        test_framing_error();
        test_false_start_overrun();

        errors += uart_core_inst.chk_inst.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
source/uart_line_pkg.sv
source/uart_host_pkg.sv
source/byte_fifo.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/uart_core.sv
bench/uart_core_chk.sv
bench/uart_core_tb.sv

//--- Makefile
TOP := uart_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: compile
	@./obj_dir/V$(TOP) > run.log 2>&1; status=$$?; cat run.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" run.log; then \
		echo "run failed, see run.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir run.log
